/* wm8960_i2c_master.f */
design/wm8960_i2c_pkg.sv
design/i2c_frame_sequencer.sv
design/i2c_bit_driver.sv
design/i2c_frame_register.sv
design/wm8960_i2c_master.sv
sim/wm8960_codec_model.sv
sim/wm8960_i2c_master_asserts.sv
sim/tb_wm8960_i2c_master.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the WM8960 I2C master testbench
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_wm8960_i2c_master

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" \
  -Mdir "$BUILD_DIR" -f wm8960_i2c_master.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
  exit 0
fi
exit 1

/* sim/tb_wm8960_i2c_master.sv */
`timescale 1ns/1ps

module tb_wm8960_i2c_master;

  import wm8960_i2c_pkg::*;

  localparam dev_addr_t CODEC_ADDR = 7'h1A;
  localparam int        TIMEOUT    = 20000;

  logic      clk;
  logic      rst_n;
  dev_addr_t req_dev_addr;
  logic      req_rd_wr;
  reg_addr_t req_reg_addr;
  reg_data_t req_reg_data;
  logic      req_valid;
  logic      req_ready;
  reg_data_t rsp_reg_data;
  ack_vec_t  rsp_acks;
  logic      rsp_valid;
  logic      rsp_ready;
  logic      sclk;
  logic      master_pull;
  logic      codec_pull;
  wire       sda;
  reg_data_t ref_regs [0:127];
  int        checks;
  int        errors;
  logic      timed_out;

  // wired-AND bus is high unless pulled
  assign sda = !(master_pull || codec_pull);

  wm8960_i2c_master #(
    .CLK_DIVIDER (10)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_dev_addr (req_dev_addr),
    .req_rd_wr    (req_rd_wr),
    .req_reg_addr (req_reg_addr),
    .req_reg_data (req_reg_data),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .sda_in       (sda),
    .sda_pull_low (master_pull),
    .sclk         (sclk),
    .rsp_reg_data (rsp_reg_data),
    .rsp_acks     (rsp_acks),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready)
  );

  wm8960_codec_model #(
    .DEV_ADDR (CODEC_ADDR)
  ) u_codec (
    .sclk         (sclk),
    .sda          (sda),
    .sda_pull_low (codec_pull)
  );

  always #20 clk = ~clk;

  task automatic run_frame(input dev_addr_t dev, input logic rd, input reg_addr_t addr,
                           input reg_data_t data, input int hold);
    int        cnt;
    ack_vec_t  exp_acks;
    reg_data_t exp_data;
    if (timed_out) begin
      return;
    end
    // an absent device leaves the bus high
    exp_acks = (dev != CODEC_ADDR) ? 3'b000 : (rd ? 3'b011 : 3'b111);
    if (!rd) begin
      exp_data = '0;
    end else if (dev != CODEC_ADDR) begin
      exp_data = '1;
    end else begin
      exp_data = ref_regs[addr];
    end
    if (!rd && dev == CODEC_ADDR) begin
      ref_regs[addr] = data;
    end
    cnt = 0;
    @(negedge clk);
    while (!req_ready && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!req_ready) begin
      timed_out = 1'b1;
      $display("Timeout: req_ready stayed low for %0d cycles", TIMEOUT);
      return;
    end
    @(posedge clk);
    #1;
    req_dev_addr = dev;
    req_rd_wr    = rd;
    req_reg_addr = addr;
    req_reg_data = data;
    req_valid    = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    cnt = 0;
    while (!rsp_valid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!rsp_valid) begin
      timed_out = 1'b1;
      $display("Timeout: no response within %0d cycles", TIMEOUT);
      return;
    end
    // back-pressure first
    repeat (hold) @(posedge clk);
    @(posedge clk);
    #1;
    rsp_ready = 1'b1;
    @(negedge clk);
    checks += 2;
    assert (rsp_acks === exp_acks) else begin
      errors++;
      $display("Error at %0t: rsp_acks expected %b, got %b", $time, exp_acks, rsp_acks);
    end
    assert (rsp_reg_data === exp_data) else begin
      errors++;
      $display("Error at %0t: rsp_reg_data expected %h, got %h", $time, exp_data, rsp_reg_data);
    end
    @(posedge clk);
    #1;
    rsp_ready = 1'b0;
  endtask

  initial begin
    dev_addr_t dev;
    logic      rd;
    reg_addr_t addr;
    reg_data_t data;
    int        hold;
    void'($urandom(15));
    clk          = 1'b0;
    rst_n        = 1'b1;
    req_dev_addr = '0;
    req_rd_wr    = 1'b0;
    req_reg_addr = '0;
    req_reg_data = '0;
    req_valid    = 1'b0;
    rsp_ready    = 1'b0;
    checks       = 0;
    errors       = 0;
    timed_out    = 1'b0;
    for (int i = 0; i < 128; i++) begin
      ref_regs[i] = reg_data_t'(i * 37 + 11);
    end
    // explicit falling edge so the asynchronous reset takes effect
    #1;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    run_frame(CODEC_ADDR, 1'b0, 7'h05, 9'h1A3, 0);
    run_frame(CODEC_ADDR, 1'b1, 7'h05, 9'h000, 3);
    run_frame(CODEC_ADDR, 1'b1, 7'h22, 9'h000, 0);
    run_frame(7'h3B, 1'b0, 7'h10, 9'h155, 1);
    run_frame(7'h3B, 1'b1, 7'h10, 9'h000, 0);
    repeat (24) begin
      dev  = ($urandom_range(3) == 0) ? dev_addr_t'($urandom) : CODEC_ADDR;
      rd   = 1'($urandom);
      addr = reg_addr_t'($urandom);
      data = reg_data_t'($urandom);
      hold = $urandom_range(6);
      run_frame(dev, rd, addr, data, hold);
    end

    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, DUT.u_asserts.fail_count, timed_out);
    if (errors == 0 && DUT.u_asserts.fail_count == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* sim/wm8960_i2c_master_asserts.sv */
`timescale 1ns/1ps

module wm8960_i2c_master_asserts (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      req_valid,
  input logic                      req_ready,
  input logic                      rsp_valid,
  input logic                      rsp_ready,
  input wm8960_i2c_pkg::reg_data_t rsp_reg_data,
  input wm8960_i2c_pkg::ack_vec_t  rsp_acks,
  input logic                      sclk,
  input logic                      sda_pull_low
);

  int fail_count = 0;

  // one frame in flight
  ready_valid_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(req_ready && rsp_valid))
    else begin
      fail_count++;
      $error("req_ready and rsp_valid high in the same cycle");
    end

  idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
    req_ready |-> sclk && !sda_pull_low)
    else begin
      fail_count++;
      $error("bus not idle while req_ready is high");
    end

  accept_drops_ready: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && req_ready |=> !req_ready)
    else begin
      fail_count++;
      $error("req_ready still high after acceptance");
    end

  response_held: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=>
      rsp_valid && $stable(rsp_reg_data) && $stable(rsp_acks) && !req_ready)
    else begin
      fail_count++;
      $error("response changed while rsp_ready was low");
    end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !req_ready && !rsp_valid && sclk && !sda_pull_low)
    else begin
      fail_count++;
      $error("control outputs active during reset");
    end

endmodule

bind wm8960_i2c_master wm8960_i2c_master_asserts u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .req_valid    (req_valid),
  .req_ready    (req_ready),
  .rsp_valid    (rsp_valid),
  .rsp_ready    (rsp_ready),
  .rsp_reg_data (rsp_reg_data),
  .rsp_acks     (rsp_acks),
  .sclk         (sclk),
  .sda_pull_low (sda_pull_low)
);

/* sim/wm8960_codec_model.sv */
`timescale 1ns/1ps

module wm8960_codec_model #(
  parameter logic [6:0] DEV_ADDR = 7'h00
) (
  input  logic sclk,
  input  logic sda,
  output logic sda_pull_low
);

  logic [8:0] regs [0:127];
  logic [7:0] shift;
  logic [3:0] nbits;
  logic [1:0] byte_idx;
  logic [6:0] reg_addr;
  logic       data_msb;
  logic       active;
  logic       selected;
  logic       rd;
  logic       sclk_q;
  logic       sda_q;

  initial begin
    sda_pull_low = 1'b0;
    active       = 1'b0;
    selected     = 1'b0;
    rd           = 1'b0;
    nbits        = '0;
    byte_idx     = '0;
    for (int i = 0; i < 128; i++) begin
      regs[i] = 9'(i * 37 + 11);
    end
  end

  // one process follows both bus lines
  always @(sclk or sda) begin
    if (sclk === 1'b1 && sclk_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
      // start condition
      active   = 1'b1;
      selected = 1'b0;
      nbits    = '0;
      byte_idx = '0;
    end else if (sclk === 1'b1 && sclk_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
      active = 1'b0;
    end else if (active && sclk_q === 1'b0 && sclk === 1'b1) begin
      if (nbits < 4'd8) begin
        shift = {shift[6:0], sda};
      end
      nbits = nbits + 4'd1;
    end else if (active && sclk_q === 1'b1 && sclk === 1'b0) begin
      sda_pull_low = 1'b0;
      if (nbits == 4'd8) begin
        case (byte_idx)
          2'd0: begin
            selected = (shift[7:1] == DEV_ADDR);
            rd       = shift[0];
          end
          2'd1: begin
            reg_addr = shift[7:1];
            data_msb = shift[0];
          end
          default: begin
            if (selected && !rd) begin
              regs[reg_addr] = {data_msb, shift};
            end
          end
        endcase
        // acks every byte it receives
        sda_pull_low = selected && !(rd && byte_idx == 2'd2);
      end else if (nbits == 4'd9) begin
        nbits    = '0;
        byte_idx = byte_idx + 2'd1;
      end
      // bit 8 of the read data rides at the end of the register byte
      if (selected && rd && nbits < 4'd8) begin
        if (byte_idx == 2'd1 && nbits == 4'd7) begin
          reg_addr     = shift[6:0];
          sda_pull_low = !regs[reg_addr][8];
        end else if (byte_idx == 2'd2) begin
          sda_pull_low = !regs[reg_addr][7 - nbits];
        end
      end
    end
    sclk_q = sclk;
    sda_q  = sda;
  end

endmodule

/* design/wm8960_i2c_master.sv */
`timescale 1ns/1ps

module wm8960_i2c_master #(
  // must be even and at least 2
  parameter int CLK_DIVIDER = 10
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  wm8960_i2c_pkg::dev_addr_t  req_dev_addr,
  input  logic                       req_rd_wr,
  input  wm8960_i2c_pkg::reg_addr_t  req_reg_addr,
  input  wm8960_i2c_pkg::reg_data_t  req_reg_data,
  input  logic                       req_valid,
  output logic                       req_ready,

  input  logic                       sda_in,
  output logic                       sda_pull_low,
  output logic                       sclk,

  output wm8960_i2c_pkg::reg_data_t  rsp_reg_data,
  output wm8960_i2c_pkg::ack_vec_t   rsp_acks,
  output logic                       rsp_valid,
  input  logic                       rsp_ready
);

  import wm8960_i2c_pkg::*;

  logic     bit_start;
  bit_cmd_t bit_cmd;
  logic     bit_done;
  logic     bit_sample;
  logic     tx_bit;
  logic     rd_wr;
  logic     capture;
  logic     tx_shift;
  logic     rx_shift;
  logic     ack_store;

  i2c_frame_sequencer u_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_ready (rsp_ready),
    .rsp_valid (rsp_valid),
    .rd_wr     (rd_wr),
    .bit_start (bit_start),
    .bit_cmd   (bit_cmd),
    .bit_done  (bit_done),
    .capture   (capture),
    .tx_shift  (tx_shift),
    .rx_shift  (rx_shift),
    .ack_store (ack_store)
  );

  i2c_bit_driver #(
    .CLK_DIVIDER (CLK_DIVIDER)
  ) u_bit_driver (
    .clk          (clk),
    .rst_n        (rst_n),
    .bit_start    (bit_start),
    .bit_cmd      (bit_cmd),
    .tx_bit       (tx_bit),
    .sda_in       (sda_in),
    .bit_done     (bit_done),
    .bit_sample   (bit_sample),
    .sclk         (sclk),
    .sda_pull_low (sda_pull_low)
  );

  i2c_frame_register u_frame_register (
    .clk          (clk),
    .rst_n        (rst_n),
    .capture      (capture),
    .req_dev_addr (req_dev_addr),
    .req_rd_wr    (req_rd_wr),
    .req_reg_addr (req_reg_addr),
    .req_reg_data (req_reg_data),
    .tx_shift     (tx_shift),
    .rx_shift     (rx_shift),
    .ack_store    (ack_store),
    .bit_sample   (bit_sample),
    .tx_bit       (tx_bit),
    .rd_wr        (rd_wr),
    .rsp_reg_data (rsp_reg_data),
    .rsp_acks     (rsp_acks)
  );

endmodule

/* design/i2c_frame_register.sv */
`timescale 1ns/1ps

module i2c_frame_register (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       capture,
  input  wm8960_i2c_pkg::dev_addr_t  req_dev_addr,
  input  logic                       req_rd_wr,
  input  wm8960_i2c_pkg::reg_addr_t  req_reg_addr,
  input  wm8960_i2c_pkg::reg_data_t  req_reg_data,
  input  logic                       tx_shift,
  input  logic                       rx_shift,
  input  logic                       ack_store,
  input  logic                       bit_sample,
  output logic                       tx_bit,
  output logic                       rd_wr,
  output wm8960_i2c_pkg::reg_data_t  rsp_reg_data,
  output wm8960_i2c_pkg::ack_vec_t   rsp_acks
);

  import wm8960_i2c_pkg::*;

  frame_t     tx_frame;
  logic [1:0] ack_idx;

  // msb first on the wire
  assign tx_bit = tx_frame[$bits(frame_t)-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_wr   <= 1'b0;
      ack_idx <= '0;
    end else begin
      if (capture) begin
        rd_wr   <= req_rd_wr;
        ack_idx <= '0;
      end else if (ack_store) begin
        ack_idx <= ack_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      tx_frame <= {req_dev_addr, req_rd_wr, req_reg_addr, req_reg_data};
    end else if (tx_shift) begin
      tx_frame <= {tx_frame[$bits(frame_t)-2:0], 1'b0};
    end
  end

  // read data stays zero for writes
  always_ff @(posedge clk) begin
    if (capture) begin
      rsp_reg_data <= '0;
    end else if (rx_shift) begin
      rsp_reg_data <= {rsp_reg_data[DATA_LOW_BITS-1:0], bit_sample};
    end
  end

  // slot is acked when sda was low
  always_ff @(posedge clk) begin
    if (capture) begin
      rsp_acks <= '0;
    end else if (ack_store) begin
      rsp_acks[ack_idx] <= ~bit_sample;
    end
  end

endmodule

/* design/i2c_bit_driver.sv */
`timescale 1ns/1ps

module i2c_bit_driver #(
  parameter int CLK_DIVIDER = 10
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bit_start,
  input  wm8960_i2c_pkg::bit_cmd_t  bit_cmd,
  input  logic                      tx_bit,
  input  logic                      sda_in,
  output logic                      bit_done,
  output logic                      bit_sample,
  output logic                      sclk,
  output logic                      sda_pull_low
);

  import wm8960_i2c_pkg::*;

  localparam delay_t HALF_WAIT = delay_t'(CLK_DIVIDER / 2 - 1);
  localparam delay_t FULL_WAIT = delay_t'(CLK_DIVIDER - 1);

  logic       busy;
  logic [2:0] phase;
  delay_t     delay_cnt;
  bit_cmd_t   cmd_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      phase        <= '0;
      delay_cnt    <= '0;
      cmd_q        <= cmd_start;
      bit_done     <= 1'b0;
      bit_sample   <= 1'b1;
      sclk         <= 1'b1;
      sda_pull_low <= 1'b0;
    end else begin
      bit_done <= 1'b0;
      if (!busy) begin
        if (bit_start) begin
          busy  <= 1'b1;
          cmd_q <= bit_cmd;
          phase <= 3'd1;
          case (bit_cmd)
            cmd_start: begin
              sclk         <= 1'b1;
              sda_pull_low <= 1'b0;
              delay_cnt    <= FULL_WAIT;
            end
            cmd_stop: begin
              sclk         <= 1'b0;
              sda_pull_low <= 1'b1;
              delay_cnt    <= FULL_WAIT;
            end
            // data bits start with half a period of setup
            default: begin
              delay_cnt <= HALF_WAIT;
            end
          endcase
        end
      end else if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end else begin
        phase <= phase + 3'd1;
        case (cmd_q)
          cmd_start: begin
            if (phase == 3'd1) begin
              // sda falls while sclk is high
              sda_pull_low <= 1'b1;
              delay_cnt    <= FULL_WAIT;
            end else begin
              sclk     <= 1'b0;
              busy     <= 1'b0;
              bit_done <= 1'b1;
            end
          end
          cmd_stop: begin
            case (phase)
              3'd1: begin
                sclk      <= 1'b1;
                delay_cnt <= FULL_WAIT;
              end
              3'd2: begin
                // sda rises while sclk is high
                sda_pull_low <= 1'b0;
                delay_cnt    <= FULL_WAIT;
              end
              default: begin
                busy     <= 1'b0;
                bit_done <= 1'b1;
              end
            endcase
          end
          cmd_write: begin
            case (phase)
              3'd1: begin
                sda_pull_low <= ~tx_bit;
                delay_cnt    <= HALF_WAIT;
              end
              3'd2: begin
                sclk      <= 1'b1;
                delay_cnt <= FULL_WAIT;
              end
              default: begin
                sclk     <= 1'b0;
                busy     <= 1'b0;
                bit_done <= 1'b1;
              end
            endcase
          end
          cmd_read: begin
            case (phase)
              3'd1: begin
                sda_pull_low <= 1'b0;
                delay_cnt    <= HALF_WAIT;
              end
              3'd2: begin
                sclk      <= 1'b1;
                delay_cnt <= HALF_WAIT;
              end
              3'd3: begin
                // middle of the high phase
                bit_sample <= sda_in;
                delay_cnt  <= HALF_WAIT;
              end
              default: begin
                sclk     <= 1'b0;
                busy     <= 1'b0;
                bit_done <= 1'b1;
              end
            endcase
          end
          default: begin
            busy <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

/* design/i2c_frame_sequencer.sv */
`timescale 1ns/1ps

module i2c_frame_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  logic                      rsp_ready,
  output logic                      rsp_valid,
  input  logic                      rd_wr,
  output logic                      bit_start,
  output wm8960_i2c_pkg::bit_cmd_t  bit_cmd,
  input  logic                      bit_done,
  output logic                      capture,
  output logic                      tx_shift,
  output logic                      rx_shift,
  output logic                      ack_store
);

  import wm8960_i2c_pkg::*;

  seq_state_t state;
  bit_count_t bit_cnt;
  logic [1:0] ack_cnt;
  logic       wait_done;
  logic       bus_state;
  logic       data_state;

  assign bus_state  = (state != st_idle) && (state != st_respond);
  assign data_state = (state == st_data_msb) || (state == st_data_low);

  // one start per bus state, then wait for the driver
  assign bit_start = bus_state && !wait_done;
  assign capture   = req_valid && req_ready;

  assign tx_shift  = bit_done && ((state == st_dev_addr) || (state == st_rd_wr) ||
                                  (state == st_reg_addr) || (data_state && !rd_wr));
  assign rx_shift  = bit_done && data_state && rd_wr;
  assign ack_store = bit_done && (state == st_ack);

  always_comb begin
    case (state)
      st_start:    bit_cmd = cmd_start;
      st_stop:     bit_cmd = cmd_stop;
      st_ack:      bit_cmd = cmd_read;
      st_data_msb: bit_cmd = rd_wr ? cmd_read : cmd_write;
      st_data_low: bit_cmd = rd_wr ? cmd_read : cmd_write;
      default:     bit_cmd = cmd_write;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      bit_cnt   <= '0;
      ack_cnt   <= '0;
      wait_done <= 1'b0;
      req_ready <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (bit_start) begin
        wait_done <= 1'b1;
      end
      if (bit_done) begin
        wait_done <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (req_valid && req_ready) begin
            req_ready <= 1'b0;
            bit_cnt   <= '0;
            ack_cnt   <= '0;
            state     <= st_start;
          end else begin
            req_ready <= 1'b1;
          end
        end
        st_start: begin
          if (bit_done) begin
            state <= st_dev_addr;
          end
        end
        st_dev_addr: begin
          if (bit_done) begin
            if (bit_cnt == bit_count_t'(DEV_ADDR_BITS - 1)) begin
              bit_cnt <= '0;
              state   <= st_rd_wr;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        st_rd_wr: begin
          if (bit_done) begin
            state <= st_ack;
          end
        end
        st_ack: begin
          if (bit_done) begin
            ack_cnt <= ack_cnt + 1'b1;
            // slot order picks the next field
            case (ack_cnt)
              2'd0:    state <= st_reg_addr;
              2'd1:    state <= st_data_low;
              default: state <= st_stop;
            endcase
          end
        end
        st_reg_addr: begin
          if (bit_done) begin
            if (bit_cnt == bit_count_t'(REG_ADDR_BITS - 1)) begin
              bit_cnt <= '0;
              state   <= st_data_msb;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        st_data_msb: begin
          if (bit_done) begin
            state <= st_ack;
          end
        end
        st_data_low: begin
          if (bit_done) begin
            if (bit_cnt == bit_count_t'(DATA_LOW_BITS - 1)) begin
              bit_cnt <= '0;
              state   <= st_ack;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        st_stop: begin
          if (bit_done) begin
            rsp_valid <= 1'b1;
            state     <= st_respond;
          end
        end
        st_respond: begin
          // hold the response until taken
          if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
            req_ready <= 1'b1;
            state     <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

/* design/wm8960_i2c_pkg.sv */
package wm8960_i2c_pkg;

  // field lengths of one codec frame
  localparam int DEV_ADDR_BITS = 7;
  localparam int REG_ADDR_BITS = 7;
  localparam int DATA_LOW_BITS = 8;

  typedef logic [DEV_ADDR_BITS-1:0] dev_addr_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [DATA_LOW_BITS:0]   reg_data_t;
  // bit 0 is the first acknowledge slot
  typedef logic [2:0]               ack_vec_t;
  // device address, rd_wr, register address, 9 data bits
  typedef logic [DEV_ADDR_BITS+REG_ADDR_BITS+DATA_LOW_BITS+1:0] frame_t;
  typedef logic [15:0]              delay_t;
  typedef logic [3:0]               bit_count_t;

  typedef enum logic [1:0] {
    cmd_start,
    cmd_stop,
    cmd_write,
    cmd_read
  } bit_cmd_t;

  typedef enum logic [3:0] {
    st_idle,
    st_start,
    st_dev_addr,
    st_rd_wr,
    st_ack,
    st_reg_addr,
    st_data_msb,
    st_data_low,
    st_stop,
    st_respond
  } seq_state_t;

endpackage
